// File: rtl/rename_pkg.sv
`default_nettype none

package rename_pkg;

    //////////////////////////////
    // sizes
    //////////////////////////////

    localparam int ARCH_REGS  = 8;
    localparam int PHYS_REGS  = 24;
    localparam int FREE_DEPTH = PHYS_REGS - ARCH_REGS;  // regs not mapped after reset
    localparam int ROB_DEPTH  = 16;

    localparam int ARCH_W      = $clog2(ARCH_REGS);
    localparam int PHYS_W      = $clog2(PHYS_REGS);
    localparam int ROB_W       = $clog2(ROB_DEPTH);
    localparam int FL_W        = $clog2(FREE_DEPTH);
    localparam int FL_COUNT_W  = $clog2(FREE_DEPTH + 1);
    localparam int ROB_COUNT_W = $clog2(ROB_DEPTH + 1);

    //////////////////////////////
    // index types
    //////////////////////////////

    typedef logic [ARCH_W-1:0]      arch_reg_t;
    typedef logic [PHYS_W-1:0]      phys_reg_t;
    typedef logic [ROB_W-1:0]       rob_idx_t;
    typedef logic [FL_W-1:0]        fl_idx_t;
    typedef logic [FL_COUNT_W-1:0]  fl_count_t;
    typedef logic [ROB_COUNT_W-1:0] rob_count_t;

    // one rob slot, done bit lives next to it in the rob
    typedef struct packed {
        arch_reg_t arch;      // destination arch reg
        logic      has_dest;
        phys_reg_t preg;      // newly allocated preg
        phys_reg_t old_preg;  // previous mapping, freed at retire
    } rob_entry_t;

endpackage

`default_nettype wire

// File: rtl/rob_alloc_if.sv
`timescale 1ns/10ps
`default_nettype none

// allocation path from the rename stage into the rob
interface rob_alloc_if;
    import rename_pkg::*;

    logic       alloc;        // one new entry this edge
    rob_entry_t alloc_entry;
    rob_idx_t   alloc_idx;    // current rob tail
    logic       full;

    modport stage (
        output alloc,
        output alloc_entry,
        input  alloc_idx,
        input  full
    );

    modport rob (
        input  alloc,
        input  alloc_entry,
        output alloc_idx,
        output full
    );

endinterface

`default_nettype wire

// File: rtl/free_list.sv
`timescale 1ns/10ps
`default_nettype none

module free_list (
    input  wire logic                 clock,
    input  wire logic                 reset,
    input  wire logic                 pop,
    input  wire logic                 push,
    input  wire rename_pkg::phys_reg_t push_preg,
    output rename_pkg::phys_reg_t      head_preg,
    output logic                       empty
);
    import rename_pkg::*;

    phys_reg_t entries [FREE_DEPTH];
    fl_idx_t   head;
    fl_idx_t   tail;
    fl_count_t count;

    function automatic fl_idx_t next_idx(input fl_idx_t idx);
        return (idx == fl_idx_t'(FREE_DEPTH - 1)) ? '0 : idx + 1'b1;
    endfunction

    assign head_preg = entries[head];
    assign empty     = (count == '0);

    //////////////////////////////
    // queue update
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            // regs above the identity mapping start out free
            for (int i = 0; i < FREE_DEPTH; i++) begin
                entries[i] <= phys_reg_t'(ARCH_REGS + i);
            end
            head  <= '0;
            tail  <= '0;  // full queue, tail wrapped onto head
            count <= fl_count_t'(FREE_DEPTH);
        end else begin
            if (push) begin
                entries[tail] <= push_preg;
                tail          <= next_idx(tail);
            end
            if (pop) begin
                head <= next_idx(head);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/map_table.sv
`timescale 1ns/10ps
`default_nettype none

module map_table (
    input  wire logic                 clock,
    input  wire logic                 reset,
    input  wire rename_pkg::arch_reg_t rd_arch_1,  // source 1
    input  wire rename_pkg::arch_reg_t rd_arch_2,  // source 2
    input  wire rename_pkg::arch_reg_t rd_arch_3,  // destination, old mapping
    input  wire logic                 wr_en,
    input  wire rename_pkg::arch_reg_t wr_arch,
    input  wire rename_pkg::phys_reg_t wr_preg,
    output rename_pkg::phys_reg_t      rd_preg_1,
    output rename_pkg::phys_reg_t      rd_preg_2,
    output rename_pkg::phys_reg_t      rd_preg_3
);
    import rename_pkg::*;

    phys_reg_t mapping [ARCH_REGS];

    // reads see the table before this edge's write
    assign rd_preg_1 = mapping[rd_arch_1];
    assign rd_preg_2 = mapping[rd_arch_2];
    assign rd_preg_3 = mapping[rd_arch_3];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                mapping[i] <= phys_reg_t'(i);  // identity
            end
        end else if (wr_en) begin
            mapping[wr_arch] <= wr_preg;
        end
    end

endmodule

`default_nettype wire

// File: rtl/reorder_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module reorder_buffer (
    input  wire logic                 clock,
    input  wire logic                 reset,
    input  wire logic                 cmp_valid,
    input  wire rename_pkg::rob_idx_t  cmp_rob_idx,
    rob_alloc_if.rob                  alloc_bus,
    output logic                       fl_push,
    output rename_pkg::phys_reg_t      fl_push_preg,
    output logic                       ret_valid,
    output rename_pkg::arch_reg_t      ret_arch,
    output logic                       ret_has_dest,
    output rename_pkg::phys_reg_t      ret_preg,
    output rename_pkg::phys_reg_t      ret_old_preg
);
    import rename_pkg::*;

    rob_entry_t            entries [ROB_DEPTH];
    logic [ROB_DEPTH-1:0]  slot_valid;
    logic [ROB_DEPTH-1:0]  slot_done;
    rob_idx_t              head;
    rob_idx_t              tail;
    rob_count_t            count;
    rob_entry_t            head_entry;
    logic                  retire;

    function automatic rob_idx_t next_idx(input rob_idx_t idx);
        return (idx == rob_idx_t'(ROB_DEPTH - 1)) ? '0 : idx + 1'b1;
    endfunction

    assign alloc_bus.alloc_idx = tail;
    assign alloc_bus.full      = (count == rob_count_t'(ROB_DEPTH));

    assign head_entry = entries[head];
    assign retire     = slot_valid[head] & slot_done[head];

    // old mapping goes back to the free list on the retire edge
    assign fl_push      = retire & head_entry.has_dest;
    assign fl_push_preg = head_entry.old_preg;

    //////////////////////////////
    // slot state
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            slot_valid <= '0;
            slot_done  <= '0;
            head       <= '0;
            tail       <= '0;
            count      <= '0;
        end else begin
            if (alloc_bus.alloc) begin
                slot_valid[tail] <= 1'b1;
                slot_done[tail]  <= 1'b0;
                tail             <= next_idx(tail);
            end
            // strobe ignored for slots not in flight
            if (cmp_valid && slot_valid[cmp_rob_idx]) begin
                slot_done[cmp_rob_idx] <= 1'b1;
            end
            if (retire) begin
                slot_valid[head] <= 1'b0;
                slot_done[head]  <= 1'b0;
                head             <= next_idx(head);
            end
            case ({alloc_bus.alloc, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (alloc_bus.alloc) begin
            entries[tail] <= alloc_bus.alloc_entry;
        end
    end

    //////////////////////////////
    // retirement outputs
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            ret_valid <= 1'b0;
        end else begin
            ret_valid <= retire;  // one cycle per retired entry
        end
    end

    always_ff @(posedge clock) begin
        if (retire) begin
            ret_arch     <= head_entry.arch;
            ret_has_dest <= head_entry.has_dest;
            ret_preg     <= head_entry.preg;
            ret_old_preg <= head_entry.old_preg;
        end
    end

endmodule

`default_nettype wire

// File: rtl/rename_stage.sv
`timescale 1ns/10ps
`default_nettype none

module rename_stage (
    input  wire logic                 clock,
    input  wire logic                 reset,
    input  wire logic                 in_valid,
    input  wire logic                 in_has_dest,
    input  wire rename_pkg::arch_reg_t in_dest,
    input  wire rename_pkg::arch_reg_t in_src1,
    input  wire rename_pkg::arch_reg_t in_src2,
    input  wire rename_pkg::phys_reg_t fl_head_preg,
    input  wire logic                 fl_empty,
    input  wire rename_pkg::phys_reg_t map_src1_preg,
    input  wire rename_pkg::phys_reg_t map_src2_preg,
    input  wire rename_pkg::phys_reg_t map_dest_preg,
    output logic                       in_ready,
    output logic                       fl_pop,
    output logic                       map_wr_en,
    output rename_pkg::arch_reg_t      map_wr_arch,
    output rename_pkg::phys_reg_t      map_wr_preg,
    output logic                       ren_valid,
    output rename_pkg::phys_reg_t      ren_src1_preg,
    output rename_pkg::phys_reg_t      ren_src2_preg,
    output rename_pkg::phys_reg_t      ren_dest_preg,
    output rename_pkg::phys_reg_t      ren_old_preg,
    output rename_pkg::rob_idx_t       ren_rob_idx,
    rob_alloc_if.stage                alloc_bus
);
    import rename_pkg::*;

    logic      accept;
    phys_reg_t new_preg;
    phys_reg_t old_preg;

    //////////////////////////////
    // accept and allocate
    //////////////////////////////

    // a dest needs a free preg, every instruction needs a rob slot
    assign in_ready = ~alloc_bus.full & (~in_has_dest | ~fl_empty);
    assign accept   = in_valid & in_ready;

    assign new_preg = in_has_dest ? fl_head_preg : '0;
    assign old_preg = in_has_dest ? map_dest_preg : '0;

    assign fl_pop      = accept & in_has_dest;
    assign map_wr_en   = fl_pop;        // remap lands on the accept edge
    assign map_wr_arch = in_dest;
    assign map_wr_preg = fl_head_preg;

    assign alloc_bus.alloc                = accept;
    assign alloc_bus.alloc_entry.arch     = in_dest;
    assign alloc_bus.alloc_entry.has_dest = in_has_dest;
    assign alloc_bus.alloc_entry.preg     = new_preg;
    assign alloc_bus.alloc_entry.old_preg = old_preg;

    //////////////////////////////
    // registered result
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            ren_valid <= 1'b0;
        end else begin
            ren_valid <= accept;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            ren_src1_preg <= map_src1_preg;  // pre-write mapping
            ren_src2_preg <= map_src2_preg;
            ren_dest_preg <= new_preg;
            ren_old_preg  <= old_preg;
            ren_rob_idx   <= alloc_bus.alloc_idx;
        end
    end

endmodule

`default_nettype wire

// File: rtl/rename_unit.sv
`timescale 1ns/10ps
`default_nettype none

module rename_unit (
    input  wire logic                 clock,
    input  wire logic                 reset,
    // instruction stream
    input  wire logic                 in_valid,
    output logic                       in_ready,
    input  wire logic                 in_has_dest,
    input  wire rename_pkg::arch_reg_t in_dest,
    input  wire rename_pkg::arch_reg_t in_src1,
    input  wire rename_pkg::arch_reg_t in_src2,
    // rename result
    output logic                       ren_valid,
    output rename_pkg::phys_reg_t      ren_src1_preg,
    output rename_pkg::phys_reg_t      ren_src2_preg,
    output rename_pkg::phys_reg_t      ren_dest_preg,
    output rename_pkg::phys_reg_t      ren_old_preg,
    output rename_pkg::rob_idx_t       ren_rob_idx,
    // completion strobe
    input  wire logic                 cmp_valid,
    input  wire rename_pkg::rob_idx_t  cmp_rob_idx,
    // retirement
    output logic                       ret_valid,
    output rename_pkg::arch_reg_t      ret_arch,
    output logic                       ret_has_dest,
    output rename_pkg::phys_reg_t      ret_preg,
    output rename_pkg::phys_reg_t      ret_old_preg
);
    import rename_pkg::*;

    phys_reg_t fl_head_preg;
    logic      fl_empty;
    logic      fl_pop;
    logic      fl_push;
    phys_reg_t fl_push_preg;

    phys_reg_t map_src1_preg;
    phys_reg_t map_src2_preg;
    phys_reg_t map_dest_preg;
    logic      map_wr_en;
    arch_reg_t map_wr_arch;
    phys_reg_t map_wr_preg;

    rob_alloc_if alloc_bus ();

    rename_stage stage_i (
        .clock         (clock),
        .reset         (reset),
        .in_valid      (in_valid),
        .in_has_dest   (in_has_dest),
        .in_dest       (in_dest),
        .in_src1       (in_src1),
        .in_src2       (in_src2),
        .fl_head_preg  (fl_head_preg),
        .fl_empty      (fl_empty),
        .map_src1_preg (map_src1_preg),
        .map_src2_preg (map_src2_preg),
        .map_dest_preg (map_dest_preg),
        .in_ready      (in_ready),
        .fl_pop        (fl_pop),
        .map_wr_en     (map_wr_en),
        .map_wr_arch   (map_wr_arch),
        .map_wr_preg   (map_wr_preg),
        .ren_valid     (ren_valid),
        .ren_src1_preg (ren_src1_preg),
        .ren_src2_preg (ren_src2_preg),
        .ren_dest_preg (ren_dest_preg),
        .ren_old_preg  (ren_old_preg),
        .ren_rob_idx   (ren_rob_idx),
        .alloc_bus     (alloc_bus.stage)
    );

    free_list free_list_i (
        .clock     (clock),
        .reset     (reset),
        .pop       (fl_pop),
        .push      (fl_push),
        .push_preg (fl_push_preg),
        .head_preg (fl_head_preg),
        .empty     (fl_empty)
    );

    // third read port looks up the dest's current mapping
    map_table map_table_i (
        .clock     (clock),
        .reset     (reset),
        .rd_arch_1 (in_src1),
        .rd_arch_2 (in_src2),
        .rd_arch_3 (in_dest),
        .wr_en     (map_wr_en),
        .wr_arch   (map_wr_arch),
        .wr_preg   (map_wr_preg),
        .rd_preg_1 (map_src1_preg),
        .rd_preg_2 (map_src2_preg),
        .rd_preg_3 (map_dest_preg)
    );

    reorder_buffer rob_i (
        .clock        (clock),
        .reset        (reset),
        .cmp_valid    (cmp_valid),
        .cmp_rob_idx  (cmp_rob_idx),
        .alloc_bus    (alloc_bus.rob),
        .fl_push      (fl_push),
        .fl_push_preg (fl_push_preg),
        .ret_valid    (ret_valid),
        .ret_arch     (ret_arch),
        .ret_has_dest (ret_has_dest),
        .ret_preg     (ret_preg),
        .ret_old_preg (ret_old_preg)
    );

endmodule

`default_nettype wire

// File: tests/tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever begin
            #5 clock = ~clock;  // 10 ns period
        end
    end

    // reset held for four rising edges
    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clock);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

// File: tests/tb_rename_unit.sv
`timescale 1ns/10ps
`default_nettype none

module tb_rename_unit;
    import rename_pkg::*;

    localparam int RUN_CYCLES    = 2000;
    localparam int HOLD_START    = 300;  // no completions in this window
    localparam int HOLD_END      = 500;
    localparam int DRAIN_TIMEOUT = 300;
    localparam int FILL_TIMEOUT  = 200;

    logic       clock;
    logic       reset;
    logic       in_valid;
    logic       in_ready;
    logic       in_has_dest;
    arch_reg_t  in_dest;
    arch_reg_t  in_src1;
    arch_reg_t  in_src2;
    logic       ren_valid;
    phys_reg_t  ren_src1_preg;
    phys_reg_t  ren_src2_preg;
    phys_reg_t  ren_dest_preg;
    phys_reg_t  ren_old_preg;
    rob_idx_t   ren_rob_idx;
    logic       cmp_valid;
    rob_idx_t   cmp_rob_idx;
    logic       ret_valid;
    arch_reg_t  ret_arch;
    logic       ret_has_dest;
    phys_reg_t  ret_preg;
    phys_reg_t  ret_old_preg;

    // reference model state
    phys_reg_t  map_m [ARCH_REGS];
    phys_reg_t  free_q [$];
    rob_entry_t rob_q [$];
    logic       done_q [$];
    rob_idx_t   slot_q [$];
    rob_idx_t   tail_m;

    // outputs predicted for the coming edge
    logic       exp_ren_valid;
    logic       exp_has_dest;
    phys_reg_t  exp_src1;
    phys_reg_t  exp_src2;
    phys_reg_t  exp_dest;
    phys_reg_t  exp_old;
    rob_idx_t   exp_idx;
    logic       exp_ret_valid;
    rob_entry_t exp_ret;

    logic [15:0] lfsr_state;
    int          dest_count;
    int          stall_cycles;

    tb_clock_gen clock_gen_i (
        .clock (clock),
        .reset (reset)
    );

    rename_unit dut_i (
        .clock         (clock),
        .reset         (reset),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_has_dest   (in_has_dest),
        .in_dest       (in_dest),
        .in_src1       (in_src1),
        .in_src2       (in_src2),
        .ren_valid     (ren_valid),
        .ren_src1_preg (ren_src1_preg),
        .ren_src2_preg (ren_src2_preg),
        .ren_dest_preg (ren_dest_preg),
        .ren_old_preg  (ren_old_preg),
        .ren_rob_idx   (ren_rob_idx),
        .cmp_valid     (cmp_valid),
        .cmp_rob_idx   (cmp_rob_idx),
        .ret_valid     (ret_valid),
        .ret_arch      (ret_arch),
        .ret_has_dest  (ret_has_dest),
        .ret_preg      (ret_preg),
        .ret_old_preg  (ret_old_preg)
    );

    //////////////////////////////
    // random bits
    //////////////////////////////

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic next_rand_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(next_rand_bit());
        end
        return v;
    endfunction

    //////////////////////////////
    // compare tasks
    //////////////////////////////

    task report_failure(input string what);
        $display("%s", what);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_phys(input string name, input phys_reg_t expected,
                              input phys_reg_t actual);
        if (actual !== expected) begin
            report_failure($sformatf("mismatch %s expected %0d actual %0d",
                                     name, expected, actual));
        end
    endtask

    task automatic check_arch(input string name, input arch_reg_t expected,
                              input arch_reg_t actual);
        if (actual !== expected) begin
            report_failure($sformatf("mismatch %s expected %0d actual %0d",
                                     name, expected, actual));
        end
    endtask

    task automatic check_rob_idx(input string name, input rob_idx_t expected,
                                 input rob_idx_t actual);
        if (actual !== expected) begin
            report_failure($sformatf("mismatch %s expected %0d actual %0d",
                                     name, expected, actual));
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            report_failure($sformatf("mismatch %s expected %b actual %b",
                                     name, expected, actual));
        end
    endtask

    //////////////////////////////
    // per-cycle checking and model
    //////////////////////////////

    task automatic check_outputs();
        check_bit("ren_valid", exp_ren_valid, ren_valid);
        if (exp_ren_valid) begin
            check_phys("ren_src1_preg", exp_src1, ren_src1_preg);
            check_phys("ren_src2_preg", exp_src2, ren_src2_preg);
            check_phys("ren_dest_preg", exp_dest, ren_dest_preg);
            check_phys("ren_old_preg", exp_old, ren_old_preg);
            check_rob_idx("ren_rob_idx", exp_idx, ren_rob_idx);
            if (exp_has_dest) begin
                // reset contents come out first from 8 upward
                if (dest_count < FREE_DEPTH) begin
                    check_phys("first_dests", phys_reg_t'(ARCH_REGS + dest_count),
                               ren_dest_preg);
                end
                dest_count++;
            end
        end
        check_bit("ret_valid", exp_ret_valid, ret_valid);
        if (exp_ret_valid) begin
            check_arch("ret_arch", exp_ret.arch, ret_arch);
            check_bit("ret_has_dest", exp_ret.has_dest, ret_has_dest);
            check_phys("ret_preg", exp_ret.preg, ret_preg);
            check_phys("ret_old_preg", exp_ret.old_preg, ret_old_preg);
        end
    endtask

    // runs from 1 ns after one edge to 1 ns after the next
    // feed_mode 0 idle, 1 random, 2 random with a dest on every instruction
    // cmp_mode 0 none, 1 random, 2 every cycle
    task automatic run_cycle(input int feed_mode, input int cmp_mode);
        int         open_pos [$];
        int         sel;
        logic       ready_m;
        logic       accept;
        logic       retire;
        rob_entry_t entry;

        check_outputs();

        if (feed_mode != 0) begin
            in_valid    = (rand_bits(2) != 0);
            in_has_dest = (rand_bits(3) != 0) || (feed_mode == 2);
            in_dest     = arch_reg_t'(rand_bits(3));
            in_src1     = arch_reg_t'(rand_bits(3));
            in_src2     = arch_reg_t'(rand_bits(3));
        end else begin
            in_valid = 1'b0;
        end

        // only slots still waiting for completion
        sel = -1;
        for (int i = 0; i < done_q.size(); i++) begin
            if (!done_q[i]) begin
                open_pos.push_back(i);
            end
        end
        if (open_pos.size() > 0 && (cmp_mode == 2 || (cmp_mode == 1 && rand_bits(1) == 1))) begin
            sel = open_pos[rand_bits(4) % open_pos.size()];
        end
        if (sel >= 0) begin
            cmp_valid   = 1'b1;
            cmp_rob_idx = slot_q[sel];
        end else begin
            cmp_valid   = 1'b0;
            cmp_rob_idx = '0;
        end

        #1;
        ready_m = (rob_q.size() < ROB_DEPTH) && (!in_has_dest || free_q.size() > 0);
        check_bit("in_ready", ready_m, in_ready);
        if (in_valid && !ready_m) begin
            stall_cycles++;
        end

        accept = in_valid && ready_m;
        retire = (rob_q.size() > 0) && done_q[0];  // done bit before this edge
        if (sel >= 0) begin
            done_q[sel] = 1'b1;
        end

        exp_ren_valid = accept;
        if (accept) begin
            entry.arch     = in_dest;
            entry.has_dest = in_has_dest;
            entry.preg     = '0;
            entry.old_preg = '0;
            if (in_has_dest) begin
                entry.old_preg = map_m[in_dest];
                entry.preg     = free_q.pop_front();
            end
            exp_src1 = map_m[in_src1];  // lookups before the remap
            exp_src2 = map_m[in_src2];
            if (in_has_dest) begin
                map_m[in_dest] = entry.preg;
            end
            exp_has_dest = in_has_dest;
            exp_dest     = entry.preg;
            exp_old      = entry.old_preg;
            exp_idx      = tail_m;
            rob_q.push_back(entry);
            done_q.push_back(1'b0);
            slot_q.push_back(tail_m);
            tail_m = tail_m + 1'b1;
        end

        exp_ret_valid = retire;
        if (retire) begin
            exp_ret = rob_q.pop_front();
            done_q.delete(0);
            slot_q.delete(0);
            if (exp_ret.has_dest) begin
                free_q.push_back(exp_ret.old_preg);  // reused after older free regs
            end
        end

        @(posedge clock);
        #1;
    endtask

    // no input while every outstanding slot gets completed
    task automatic drain_rob();
        int wait_cycles;
        wait_cycles = 0;
        while (rob_q.size() > 0 || exp_ret_valid || exp_ren_valid) begin
            run_cycle(0, 2);
            wait_cycles++;
            if (wait_cycles > DRAIN_TIMEOUT) begin
                report_failure("retirement stalled before the reorder buffer drained");
            end
        end
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        int wait_cycles;
        int mode;

        in_valid    = 1'b0;
        in_has_dest = 1'b0;
        in_dest     = '0;
        in_src1     = '0;
        in_src2     = '0;
        cmp_valid   = 1'b0;
        cmp_rob_idx = '0;

        lfsr_state = 16'd61416;
        for (int i = 0; i < ARCH_REGS; i++) begin
            map_m[i] = phys_reg_t'(i);
        end
        for (int i = 0; i < FREE_DEPTH; i++) begin
            free_q.push_back(phys_reg_t'(ARCH_REGS + i));
        end
        tail_m        = '0;
        exp_ren_valid = 1'b0;
        exp_ret_valid = 1'b0;
        dest_count    = 0;
        stall_cycles  = 0;

        wait_cycles = 0;
        do begin
            @(posedge clock);
            #1;
            wait_cycles++;
            if (wait_cycles > 20) begin
                report_failure("reset was never released");
            end
        end while (reset !== 1'b0);

        check_bit("ready_after_reset", 1'b1, in_ready);

        for (int cyc = 0; cyc < RUN_CYCLES; cyc++) begin
            mode = (cyc >= HOLD_START && cyc < HOLD_END) ? 0 : 1;
            run_cycle(1, mode);
        end

        drain_rob();

        // all 16 free regs must come back out of the DUT in model order
        wait_cycles = 0;
        while (rob_q.size() < ROB_DEPTH) begin
            run_cycle(2, 0);
            wait_cycles++;
            if (wait_cycles > FILL_TIMEOUT) begin
                report_failure("reorder buffer never filled after the drain");
            end
        end

        drain_rob();
        check_outputs();

        if (stall_cycles == 0) begin
            report_failure("input never stalled while completions were held back");
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: filelist.f
rtl/rename_pkg.sv
rtl/rob_alloc_if.sv
rtl/free_list.sv
rtl/map_table.sv
rtl/reorder_buffer.sv
rtl/rename_stage.sv
rtl/rename_unit.sv
tests/tb_clock_gen.sv
tests/tb_rename_unit.sv

// File: run_sim.sh
#!/bin/sh
# build and run the rename unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f filelist.f --top-module tb_rename_unit -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vtb_rename_unit
status=$?
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit $status
fi

exit 0
